/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP      = tb_video_top
FILELIST = filelist.f
OBJ_DIR  = obj_dir
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
hw/video_pkg.sv
hw/video_ifs.sv
hw/video_timer.sv
hw/tile_layer.sv
hw/obj_layer.sv
hw/colour_mixer.sv
hw/video_top.sv
tb/tb_video_top.sv

/* hw/colour_mixer.sv */
`default_nettype none

module colour_mixer import video_pkg::*; (
    input  logic       clk,
    input  logic       pxl_cen,
    input  logic       prom_en,
    input  pal_idx_t   prog_addr,
    input  logic [7:0] prog_data,
    raster_if.sink     rst,
    input  pxl_t       obj_pxl,
    input  pxl_t       scr_pxl,
    output colour_t    red,
    output colour_t    green,
    output colour_t    blue,
    output logic       lhbl_dly,
    output logic       lvbl_dly
);

    // Palette PROM image, loaded at start-up
    logic [7:0] pal [2**$bits(pal_idx_t)];

    pal_idx_t   idx;
    logic [7:0] pal_byte;
    logic [1:0] lhbl_sh;
    logic [1:0] lvbl_sh;
    logic       active;

    always_ff @(posedge clk) begin
        if (prom_en) begin
            pal[prog_addr] <= prog_data;
        end
    end

    // Sprites sit in the upper half of the palette
    assign idx = obj_pxl != '0 ? {1'b1, obj_pxl} : {1'b0, scr_pxl};
    assign pal_byte = pal[idx];

    // Blanking lags two stages to meet the layer pixels
    assign active = lhbl_sh[1] && lvbl_sh[1];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            lhbl_sh  <= {lhbl_sh[0], rst.lhbl};
            lvbl_sh  <= {lvbl_sh[0], rst.lvbl};
            lhbl_dly <= lhbl_sh[1];
            lvbl_dly <= lvbl_sh[1];
            red      <= active ? expand_red(pal_byte) : '0;
            green    <= active ? expand_green(pal_byte) : '0;
            blue     <= active ? expand_blue(pal_byte) : '0;
        end
    end

endmodule

`default_nettype wire

/* hw/obj_layer.sv */
`default_nettype none

module obj_layer import video_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  logic [10:0] cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        cpu_rnw,
    input  logic        obj_ram_cs,
    output logic [7:0]  obj_dout,
    raster_if.sink      rst,
    rom_if.master       rom,
    output pxl_t        pxl
);

    localparam int IDX_W = $clog2(NUM_OBJ);

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        FETCH,
        DRAW
    } state_t;

    // Four bytes per sprite: x, y, code, attr
    logic [7:0] tbl [4*NUM_OBJ];

    state_t            state;
    logic [IDX_W-1:0]  idx;
    logic              last_idx;
    logic              hinit_cen;
    logic [8:0]        line;
    logic [8:0]        dy;
    logic              hit;
    logic [7:0]        spr_x;
    logic [7:0]        spr_code;
    logic [3:0]        spr_row;
    logic              half;
    logic [ROM_DW-1:0] word;
    logic [2:0]        px_cnt;
    logic [8:0]        draw_pos;
    pxl_t              px_new;
    pxl_t              px_old;
    logic              draw_we;
    logic              clr_we;
    logic              disp_sel;
    logic              show;
    pxl_t              rd_show [2];
    pxl_t              rd_draw [2];
    pxl_t              disp_q;

    always_ff @(posedge clk) begin
        if (obj_ram_cs && !cpu_rnw) begin
            tbl[cpu_addr[5:0]] <= cpu_dout;
        end
        obj_dout <= tbl[cpu_addr[5:0]];
    end

    assign hinit_cen = pxl_cen && rst.hinit;
    assign last_idx  = idx == IDX_W'(NUM_OBJ - 1);

    // Sprite covers the line when line - y is in 0..15
    assign dy  = line - {1'b0, tbl[{idx, 2'd1}]};
    assign hit = dy[8:4] == 5'd0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            idx      <= '0;
            half     <= 1'b0;
            px_cnt   <= '0;
            rom.cs   <= 1'b0;
            disp_sel <= 1'b0;
        end else if (hinit_cen) begin
            // New line, unfinished sprites are dropped
            disp_sel <= ~disp_sel;
            state    <= SCAN;
            idx      <= '0;
            rom.cs   <= 1'b0;
        end else begin
            case (state)
                SCAN: begin
                    if (hit) begin
                        half   <= 1'b0;
                        rom.cs <= 1'b1;
                        state  <= FETCH;
                    end else if (last_idx) begin
                        state <= IDLE;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                FETCH: begin
                    if (rom.ok) begin
                        rom.cs <= 1'b0;
                        px_cnt <= '0;
                        state  <= DRAW;
                    end
                end
                DRAW: begin
                    px_cnt <= px_cnt + 3'd1;
                    if (px_cnt == 3'd7) begin
                        if (!half) begin
                            half   <= 1'b1;
                            rom.cs <= 1'b1;
                            state  <= FETCH;
                        end else if (last_idx) begin
                            state <= IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= SCAN;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hinit_cen) begin
            line <= rst.vrender;
        end
        if (state == SCAN && hit) begin
            spr_x    <= tbl[{idx, 2'd0}];
            spr_code <= tbl[{idx, 2'd2}];
            spr_row  <= dy[3:0];
        end
        if (state == FETCH && rom.cs && rom.ok) begin
            word <= rom.data;
        end
    end

    assign rom.addr = {spr_code, spr_row, half};

    assign px_new   = word[{px_cnt, 2'b00} +: 4];
    assign draw_pos = {1'b0, spr_x} + {5'd0, half, px_cnt};
    assign px_old   = rd_draw[~disp_sel];

    // Earlier sprites keep their pixels, off-screen pixels are skipped
    assign draw_we = state == DRAW && !rst.hinit && !draw_pos[8]
                     && px_new != '0 && px_old == '0;

    // Display half already swapped while hinit is high
    assign show   = disp_sel ^ rst.hinit;
    assign clr_we = pxl_cen && !rst.hdump[8];

    for (genvar k = 0; k < 2; k++) begin : g_lbuf
        pxl_t mem [256];

        always_ff @(posedge clk) begin
            if (clr_we && show == 1'(k)) begin
                mem[rst.hdump[7:0]] <= '0;
            end else if (draw_we && disp_sel != 1'(k)) begin
                mem[draw_pos[7:0]] <= px_new;
            end
        end

        assign rd_show[k] = mem[rst.hdump[7:0]];
        assign rd_draw[k] = mem[draw_pos[7:0]];
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            disp_q <= rst.hdump[8] ? '0 : rd_show[show];
            pxl    <= disp_q;
        end
    end

endmodule

`default_nettype wire

/* hw/tile_layer.sv */
`default_nettype none

module tile_layer import video_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  logic [10:0] cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        cpu_rnw,
    input  logic        vram_cs,
    output logic [7:0]  vram_dout,
    raster_if.sink      rst,
    rom_if.master       rom,
    output pxl_t        pxl
);

    // Clock cycles the ROM gets before the tile is blanked
    localparam int ROM_WAIT = 6;

    // Codes in the lower 1 KB, attributes in the upper
    logic [7:0] code_ram [1024];
    logic [7:0] attr_ram [1024];

    logic              tile_start;
    logic [8:0]        fetch_line;
    logic [4:0]        fetch_col;
    logic [9:0]        map_addr;
    logic [7:0]        code_q;
    logic [7:0]        attr_q;
    logic [2:0]        row_q;
    logic              lookup;
    logic [2:0]        wait_cnt;
    logic [ROM_DW-1:0] next_word;
    logic              next_ok;
    logic              next_flip;
    logic [ROM_DW-1:0] shift;
    logic              cur_flip;

    always_ff @(posedge clk) begin
        if (vram_cs && !cpu_rnw) begin
            if (cpu_addr[10]) begin
                attr_ram[cpu_addr[9:0]] <= cpu_dout;
            end else begin
                code_ram[cpu_addr[9:0]] <= cpu_dout;
            end
        end
        vram_dout <= cpu_addr[10] ? attr_ram[cpu_addr[9:0]] : code_ram[cpu_addr[9:0]];
    end

    // Fetch runs one tile ahead of the shifter
    assign tile_start = pxl_cen && rst.hdump[2:0] == 3'd0;

    // In blanking, prepare column 0 of the next line
    assign fetch_line = rst.hdump[8] ? rst.vrender : rst.vdump;
    assign fetch_col  = rst.hdump[8] ? 5'd0 : rst.hdump[7:3] + 5'd1;
    assign map_addr   = {fetch_line[7:3], fetch_col};

    always_ff @(posedge clk) begin
        if (tile_start) begin
            code_q <= code_ram[map_addr];
            attr_q <= attr_ram[map_addr];
            row_q  <= fetch_line[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lookup   <= 1'b0;
            rom.cs   <= 1'b0;
            wait_cnt <= '0;
            next_ok  <= 1'b0;
        end else begin
            lookup <= tile_start;
            if (lookup) begin
                rom.cs   <= 1'b1;
                wait_cnt <= '0;
            end else if (rom.cs) begin
                if (rom.ok) begin
                    rom.cs  <= 1'b0;
                    next_ok <= 1'b1;
                end else if (wait_cnt == 3'(ROM_WAIT - 1)) begin
                    // Too late, this tile shows as transparent
                    rom.cs <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt + 3'd1;
                end
            end
            if (tile_start) begin
                next_ok <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            rom.addr  <= {attr_q[0], code_q, row_q};
            next_flip <= attr_q[6];
        end
        if (rom.cs && rom.ok) begin
            next_word <= rom.data;
        end
    end

    // Flipped tiles shift out from the top nibble
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pxl <= cur_flip ? shift[31:28] : shift[3:0];
            if (tile_start) begin
                shift    <= next_ok ? next_word : '0;
                cur_flip <= next_flip;
            end else if (cur_flip) begin
                shift <= {shift[27:0], 4'd0};
            end else begin
                shift <= {4'd0, shift[31:4]};
            end
        end
    end

endmodule

`default_nettype wire

/* hw/video_ifs.sv */
`default_nettype none

// Raster position and blanking from the timing generator
interface raster_if;
    logic [8:0] hdump;
    logic [8:0] vdump;
    // Line being rendered by the object layer
    logic [8:0] vrender;
    logic       lhbl;
    logic       lvbl;
    logic       hinit;

    modport source (
        output hdump,
        output vdump,
        output vrender,
        output lhbl,
        output lvbl,
        output hinit
    );

    modport sink (
        input  hdump,
        input  vdump,
        input  vrender,
        input  lhbl,
        input  lvbl,
        input  hinit
    );
endinterface

// Graphics ROM request, cs and addr held until ok
interface rom_if import video_pkg::*; #(
    parameter int AW = 12
) ();
    logic              cs;
    logic [AW-1:0]     addr;
    logic [ROM_DW-1:0] data;
    logic              ok;

    modport master (
        output cs,
        output addr,
        input  data,
        input  ok
    );
endinterface

`default_nettype wire

/* hw/video_pkg.sv */
`default_nettype none

package video_pkg;

    // Layer pixel, 0 is transparent
    typedef logic [3:0] pxl_t;
    typedef logic [4:0] pal_idx_t;
    typedef logic [3:0] colour_t;

    localparam int TILE_ROM_AW = 12;
    localparam int OBJ_ROM_AW  = 13;
    // Eight 4-bit pixels per word, pixel 0 in the low nibble
    localparam int ROM_DW      = 32;
    localparam int NUM_OBJ     = 16;

    // PROM byte layout is RRRGGGBB with red in the low bits
    function automatic colour_t expand_red(input logic [7:0] pal_byte);
        return {pal_byte[2:0], pal_byte[2]};
    endfunction

    function automatic colour_t expand_green(input logic [7:0] pal_byte);
        return {pal_byte[5:3], pal_byte[5]};
    endfunction

    function automatic colour_t expand_blue(input logic [7:0] pal_byte);
        return {pal_byte[7:6], pal_byte[7:6]};
    endfunction

endpackage

`default_nettype wire

/* hw/video_timer.sv */
`default_nettype none

module video_timer #(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 256,
    parameter int V_TOTAL  = 264,
    parameter int V_ACTIVE = 224,
    parameter int HS_START = 300,
    parameter int HS_END   = 318,
    parameter int VS_START = 254,
    parameter int VS_END   = 258
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pxl_cen,
    raster_if.source rst,
    output logic     HS,
    output logic     VS,
    output logic     V16
);

    // First visible line
    localparam int V_START = 16;

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       h_last;
    logic       v_last;

    assign h_last = hcnt == 9'(H_TOTAL - 1);
    assign v_last = vcnt == 9'(V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hcnt <= '0;
                vcnt <= v_last ? 9'd0 : vcnt + 9'd1;
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    assign rst.hdump   = hcnt;
    assign rst.vdump   = vcnt;
    assign rst.vrender = v_last ? 9'd0 : vcnt + 9'd1;

    // High for the whole of hdump 0, so exactly one pxl_cen
    assign rst.hinit = hcnt == 9'd0;

    assign rst.lhbl = hcnt < 9'(H_ACTIVE);
    assign rst.lvbl = vcnt >= 9'(V_START) && vcnt < 9'(V_START + V_ACTIVE);

    // Both syncs active low
    assign HS = !(hcnt >= 9'(HS_START) && hcnt < 9'(HS_END));
    assign VS = !(vcnt >= 9'(VS_START) && vcnt < 9'(VS_END));

    assign V16 = vcnt[4];

endmodule

`default_nettype wire

/* hw/video_top.sv */
`default_nettype none

module video_top import video_pkg::*; #(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 256,
    parameter int V_TOTAL  = 264,
    parameter int V_ACTIVE = 224,
    parameter int HS_START = 300,
    parameter int HS_END   = 318,
    parameter int VS_START = 254,
    parameter int VS_END   = 258
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    // CPU bus
    input  logic [10:0]            cpu_addr,
    input  logic [7:0]             cpu_dout,
    input  logic                   cpu_rnw,
    input  logic                   vram_cs,
    input  logic                   obj_ram_cs,
    output logic [7:0]             vram_dout,
    output logic [7:0]             obj_dout,
    // Palette PROM load
    input  logic                   prom_en,
    input  pal_idx_t               prog_addr,
    input  logic [7:0]             prog_data,
    // Tile ROM
    output logic                   scr_cs,
    output logic [TILE_ROM_AW-1:0] scr_addr,
    input  logic [ROM_DW-1:0]      scr_data,
    input  logic                   scr_ok,
    // Object ROM
    output logic                   obj_cs,
    output logic [OBJ_ROM_AW-1:0]  obj_addr,
    input  logic [ROM_DW-1:0]      obj_data,
    input  logic                   obj_ok,
    // Video out
    output logic                   HS,
    output logic                   VS,
    output logic                   V16,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly,
    output colour_t                red,
    output colour_t                green,
    output colour_t                blue
);

    raster_if                  raster ();
    rom_if #(.AW(TILE_ROM_AW)) scr_rom ();
    rom_if #(.AW(OBJ_ROM_AW))  obj_rom ();

    pxl_t scr_pxl;
    pxl_t obj_pxl;

    assign scr_cs       = scr_rom.cs;
    assign scr_addr     = scr_rom.addr;
    assign scr_rom.data = scr_data;
    assign scr_rom.ok   = scr_ok;

    assign obj_cs       = obj_rom.cs;
    assign obj_addr     = obj_rom.addr;
    assign obj_rom.data = obj_data;
    assign obj_rom.ok   = obj_ok;

    video_timer #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .HS_START (HS_START),
        .HS_END   (HS_END),
        .VS_START (VS_START),
        .VS_END   (VS_END)
    ) u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .rst     (raster),
        .HS      (HS),
        .VS      (VS),
        .V16     (V16)
    );

    tile_layer u_scroll (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_rnw   (cpu_rnw),
        .vram_cs   (vram_cs),
        .vram_dout (vram_dout),
        .rst       (raster),
        .rom       (scr_rom),
        .pxl       (scr_pxl)
    );

    obj_layer u_obj (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .cpu_rnw    (cpu_rnw),
        .obj_ram_cs (obj_ram_cs),
        .obj_dout   (obj_dout),
        .rst        (raster),
        .rom        (obj_rom),
        .pxl        (obj_pxl)
    );

    colour_mixer u_colmix (
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .prom_en   (prom_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rst       (raster),
        .obj_pxl   (obj_pxl),
        .scr_pxl   (scr_pxl),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl_dly  (lhbl_dly),
        .lvbl_dly  (lvbl_dly)
    );

endmodule

`default_nettype wire

/* tb/tb_video_top.sv */
`default_nettype none

module tb_video_top import video_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_TOTAL  = 384;
    localparam int H_ACTIVE = 256;
    localparam int V_TOTAL  = 264;
    localparam int V_ACTIVE = 224;
    localparam int V_START  = 16;
    localparam int VS_START = 254;
    localparam int CLK_NS   = 100;
    localparam logic [31:0] SEED = 32'h7441a32a;
    localparam longint WATCHDOG_NS = 64'd3 * H_TOTAL * V_TOTAL * 2 * CLK_NS;

    localparam logic [2:0] K_VRAM_WR = 3'd0;
    localparam logic [2:0] K_VRAM_RD = 3'd1;
    localparam logic [2:0] K_OBJ_WR  = 3'd2;
    localparam logic [2:0] K_OBJ_RD  = 3'd3;
    localparam logic [2:0] K_PROM    = 3'd4;

    typedef struct packed {
        logic [2:0]  kind;
        logic [10:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp_v;
    } row_t;

    logic clk;
    logic rst_n;
    logic pxl_cen = 1'b0;
    logic [10:0] cpu_addr;
    logic [7:0] cpu_dout;
    logic cpu_rnw;
    logic vram_cs;
    logic obj_ram_cs;
    logic [7:0] vram_dout;
    logic [7:0] obj_dout;
    logic prom_en;
    pal_idx_t prog_addr;
    logic [7:0] prog_data;
    logic scr_cs;
    logic [TILE_ROM_AW-1:0] scr_addr;
    logic [ROM_DW-1:0] scr_data = '0;
    logic scr_ok = 1'b0;
    logic obj_cs;
    logic [OBJ_ROM_AW-1:0] obj_addr;
    logic [ROM_DW-1:0] obj_data = '0;
    logic obj_ok = 1'b0;
    logic HS;
    logic VS;
    logic V16;
    logic lhbl_dly;
    logic lvbl_dly;
    colour_t red;
    colour_t green;
    colour_t blue;

    row_t rows[$];
    logic [7:0] spr_x [NUM_OBJ];
    logic [7:0] spr_y [NUM_OBJ];
    logic [7:0] spr_code [NUM_OBJ];

    int unsigned scr_cnt = 0;
    int unsigned scr_delay = 1;
    int unsigned obj_cnt = 0;
    int unsigned obj_delay = 1;

    // Monitor state
    logic checking = 1'b0;
    logic prev_lhbl = 1'b0;
    logic prev_lvbl = 1'b0;
    logic prev_vs = 1'b1;
    logic line_armed = 1'b0;
    logic frame_armed = 1'b0;
    logic vs_armed = 1'b0;
    logic pos_armed = 1'b0;
    int h_pos = 0;
    int v_pos = 0;
    int pcnt_line = 0;
    int pcnt_frame = 0;
    int act_cnt = 0;
    int vlines = 0;
    int vs_falls = 0;
    int see_through = 0;
    int overlap_shown = 0;
    int err_count = 0;

    video_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .cpu_rnw    (cpu_rnw),
        .vram_cs    (vram_cs),
        .obj_ram_cs (obj_ram_cs),
        .vram_dout  (vram_dout),
        .obj_dout   (obj_dout),
        .prom_en    (prom_en),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .scr_cs     (scr_cs),
        .scr_addr   (scr_addr),
        .scr_data   (scr_data),
        .scr_ok     (scr_ok),
        .obj_cs     (obj_cs),
        .obj_addr   (obj_addr),
        .obj_data   (obj_data),
        .obj_ok     (obj_ok),
        .HS         (HS),
        .VS         (VS),
        .V16        (V16),
        .lhbl_dly   (lhbl_dly),
        .lvbl_dly   (lvbl_dly),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    // Memory fill patterns
    function automatic logic [7:0] code_of(input logic [9:0] a);
        return 8'(a * 10'd37) ^ 8'(a >> 2);
    endfunction

    // Flip from address parity, code bit 8 from address bit 7
    function automatic logic [7:0] attr_of(input logic [9:0] a);
        return {1'b0, ^a, 5'd0, a[7]};
    endfunction

    function automatic logic [7:0] pal_of(input pal_idx_t i);
        return 8'(i * 8'd53 + 8'd29);
    endfunction

    function automatic logic [31:0] tile_word(input logic [TILE_ROM_AW-1:0] a);
        return {20'd0, a} * 32'h01010101 + 32'h00112233;
    endfunction

    // Nibbles 1 and 5 always zero, so every sprite has see-through columns
    function automatic logic [31:0] obj_word(input logic [OBJ_ROM_AW-1:0] a);
        return ({19'd0, a} * 32'h01315171 + 32'h2468ACE1) & 32'hFF0FFF0F;
    endfunction

    function automatic pxl_t tile_pixel(input logic [7:0] x, input logic [8:0] v);
        logic [9:0]  a;
        logic [7:0]  attr;
        logic [31:0] w;
        logic [2:0]  n;
        a    = {v[7:3], x[7:3]};
        attr = attr_of(a);
        w    = tile_word({attr[0], code_of(a), v[2:0]});
        n    = attr[6] ? 3'd7 - x[2:0] : x[2:0];
        return w[{n, 2'b00} +: 4];
    endfunction

    // First nonzero pixel in table order, hits counts covering sprites
    function automatic pxl_t obj_pixel(input int x, input logic [8:0] v, output int hits);
        logic [8:0]  dy;
        int          dx;
        logic [31:0] w;
        pxl_t        p;
        pxl_t        found;
        found = '0;
        hits  = 0;
        for (int i = 0; i < NUM_OBJ; i++) begin
            dy = v - {1'b0, spr_y[i]};
            dx = x - int'(spr_x[i]);
            if (dy < 9'd16 && dx >= 0 && dx < 16) begin
                hits++;
                w = obj_word({spr_code[i], dy[3:0], dx[3]});
                p = w[{dx[2:0], 2'b00} +: 4];
                if (found == '0) begin
                    found = p;
                end
            end
        end
        return found;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp_v,
                            input logic [31:0] got_v);
        assert (exp_v === got_v) else begin
            err_count++;
            $display("ERROR time=%0t %s expected %0h got %0h", $time, name, exp_v, got_v);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic build_table();
        logic [10:0] a;
        // Three overlapping sprites, the rest parked below the screen
        for (int i = 0; i < NUM_OBJ; i++) begin
            spr_x[i]    = 8'(i * 16);
            spr_y[i]    = 8'd240;
            spr_code[i] = 8'(i);
        end
        spr_x[0] = 8'd40;
        spr_y[0] = 8'd60;
        spr_code[0] = 8'h11;
        spr_x[1] = 8'd48;
        spr_y[1] = 8'd66;
        spr_code[1] = 8'h22;
        spr_x[2] = 8'd44;
        spr_y[2] = 8'd70;
        spr_code[2] = 8'h33;
        for (int i = 0; i < 32; i++) begin
            rows.push_back({K_PROM, 11'(i), pal_of(5'(i)), 8'd0});
        end
        for (int i = 0; i < 1024; i++) begin
            rows.push_back({K_VRAM_WR, 11'(i), code_of(10'(i)), 8'd0});
            rows.push_back({K_VRAM_WR, 11'(i + 1024), attr_of(10'(i)), 8'd0});
        end
        for (int i = 0; i < 2048; i += 61) begin
            a = 11'(i);
            rows.push_back({K_VRAM_RD, a, 8'd0, a[10] ? attr_of(a[9:0]) : code_of(a[9:0])});
        end
        for (int i = 0; i < NUM_OBJ; i++) begin
            rows.push_back({K_OBJ_WR, 11'(4 * i), spr_x[i], 8'd0});
            rows.push_back({K_OBJ_WR, 11'(4 * i + 1), spr_y[i], 8'd0});
            rows.push_back({K_OBJ_WR, 11'(4 * i + 2), spr_code[i], 8'd0});
            rows.push_back({K_OBJ_WR, 11'(4 * i + 3), 8'(i), 8'd0});
        end
        for (int i = 0; i < NUM_OBJ; i++) begin
            rows.push_back({K_OBJ_RD, 11'(4 * i), 8'd0, spr_x[i]});
            rows.push_back({K_OBJ_RD, 11'(4 * i + 1), 8'd0, spr_y[i]});
            rows.push_back({K_OBJ_RD, 11'(4 * i + 2), 8'd0, spr_code[i]});
            rows.push_back({K_OBJ_RD, 11'(4 * i + 3), 8'd0, 8'(i)});
        end
    endtask

    // One row per clock, reads checked one clock later
    task automatic apply_table();
        row_t r;
        foreach (rows[i]) begin
            r          = rows[i];
            cpu_addr   = r.addr;
            cpu_dout   = r.data;
            cpu_rnw    = !(r.kind == K_VRAM_WR || r.kind == K_OBJ_WR);
            vram_cs    = r.kind == K_VRAM_WR || r.kind == K_VRAM_RD;
            obj_ram_cs = r.kind == K_OBJ_WR || r.kind == K_OBJ_RD;
            prom_en    = r.kind == K_PROM;
            prog_addr  = r.addr[4:0];
            prog_data  = r.data;
            @(negedge clk);
            if (r.kind == K_VRAM_RD) begin
                check_eq("vram_dout", 32'(r.exp_v), 32'(vram_dout));
            end
            if (r.kind == K_OBJ_RD) begin
                check_eq("obj_dout", 32'(r.exp_v), 32'(obj_dout));
            end
            vram_cs    = 1'b0;
            obj_ram_cs = 1'b0;
            prom_en    = 1'b0;
            cpu_rnw    = 1'b1;
        end
    endtask

    task automatic monitor_step();
        pxl_t       tp;
        pxl_t       op;
        pal_idx_t   idx;
        logic [7:0] pb;
        int         hits;
        pcnt_line++;
        pcnt_frame++;
        // Raster position, locked to the timer at the VS fall
        if (pos_armed) begin
            h_pos++;
            if (h_pos == H_TOTAL) begin
                h_pos = 0;
                v_pos = (v_pos + 1) % V_TOTAL;
            end
        end
        if (!VS && prev_vs) begin
            if (vs_armed) begin
                check_eq("VS period", 32'(H_TOTAL * V_TOTAL), 32'(pcnt_frame));
            end
            vs_armed   = 1'b1;
            pcnt_frame = 0;
            vs_falls++;
            pos_armed  = 1'b1;
            h_pos      = 0;
            v_pos      = VS_START;
        end
        if (pos_armed) begin
            check_eq("V16", 32'((v_pos >> 4) & 1), 32'(V16));
        end
        if (lvbl_dly && !prev_lvbl) begin
            frame_armed = 1'b1;
            vlines      = 0;
        end
        if (!lvbl_dly && prev_lvbl && frame_armed) begin
            check_eq("lvbl_dly lines", 32'(V_ACTIVE), 32'(vlines));
        end
        if (lhbl_dly && !prev_lhbl) begin
            if (line_armed) begin
                check_eq("line length", 32'(H_TOTAL), 32'(pcnt_line));
            end
            line_armed = 1'b1;
            pcnt_line  = 0;
            act_cnt    = 0;
        end
        if (!lhbl_dly && prev_lhbl && line_armed) begin
            check_eq("lhbl_dly width", 32'(H_ACTIVE), 32'(act_cnt));
            if (prev_lvbl) begin
                vlines++;
            end
        end
        if (lhbl_dly && lvbl_dly) begin
            if (frame_armed) begin
                tp  = tile_pixel(8'(act_cnt), 9'(vlines + V_START));
                op  = obj_pixel(act_cnt, 9'(vlines + V_START), hits);
                idx = op != '0 ? {1'b1, op} : {1'b0, tp};
                pb  = pal_of(idx);
                check_eq("red", 32'(expand_red(pb)), 32'(red));
                check_eq("green", 32'(expand_green(pb)), 32'(green));
                check_eq("blue", 32'(expand_blue(pb)), 32'(blue));
                if (hits > 0 && op == '0) begin
                    see_through++;
                end
                if (hits > 1 && op != '0) begin
                    overlap_shown++;
                end
            end
        end else begin
            check_eq("red in blank", 32'd0, 32'(red));
            check_eq("green in blank", 32'd0, 32'(green));
            check_eq("blue in blank", 32'd0, 32'(blue));
        end
        if (lhbl_dly) begin
            act_cnt++;
        end
        prev_lhbl = lhbl_dly;
        prev_lvbl = lvbl_dly;
        prev_vs   = VS;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Outputs move on pxl_cen posedges, so sample before toggling pxl_cen
    always @(negedge clk) begin
        if (pxl_cen && checking) begin
            monitor_step();
        end
        pxl_cen = ~pxl_cen;
    end

    // Tile ROM with 1 to 4 cycles of latency
    always @(negedge clk) begin
        if (scr_cs !== 1'b1) begin
            scr_ok    = 1'b0;
            scr_cnt   = 0;
            scr_delay = 1 + ($urandom % 4);
        end else if (!scr_ok) begin
            scr_cnt++;
            if (scr_cnt >= scr_delay) begin
                scr_data = tile_word(scr_addr);
                scr_ok   = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (obj_cs !== 1'b1) begin
            obj_ok    = 1'b0;
            obj_cnt   = 0;
            obj_delay = 1 + ($urandom % 4);
        end else if (!obj_ok) begin
            obj_cnt++;
            if (obj_cnt >= obj_delay) begin
                obj_data = obj_word(obj_addr);
                obj_ok   = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within three frames");
        $display("=== FAIL ===");
        $fatal(1, "watchdog");
    end

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        cpu_addr   = '0;
        cpu_dout   = '0;
        cpu_rnw    = 1'b1;
        vram_cs    = 1'b0;
        obj_ram_cs = 1'b0;
        prom_en    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        build_table();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("HS after reset", 32'd1, 32'(HS));
        check_eq("VS after reset", 32'd1, 32'(VS));
        check_eq("scr_cs after reset", 32'd0, 32'(scr_cs));
        check_eq("obj_cs after reset", 32'd0, 32'(obj_cs));
        apply_table();
        // Check one whole frame between two VS falls
        @(negedge VS);
        checking = 1'b1;
        wait (vs_falls == 2);
        assert (see_through > 0 && overlap_shown > 0) else begin
            err_count++;
            $display("Sprite check saw no see-through or no overlapping sprite pixels");
        end
        if (err_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire
